// ==== forward_sel.sv ====
////////////////////////////////////////
// Forwarding source select
// Youngest matching stage wins for rs, rt
////////////////////////////////////////

module forward_sel (
    input  hazard_pkg::reg_addr_t  rs,
    input  hazard_pkg::reg_addr_t  rt,
    input  hazard_pkg::stage_tag_t ex_tag,
    input  hazard_pkg::stage_tag_t mem_tag,
    input  hazard_pkg::stage_tag_t wb_tag,
    output hazard_pkg::fwd_sel_t   fwd_rs,
    output hazard_pkg::fwd_sel_t   fwd_rt
);

    function automatic hazard_pkg::fwd_sel_t pick(
        hazard_pkg::reg_addr_t  a,
        hazard_pkg::stage_tag_t ex,
        hazard_pkg::stage_tag_t mem,
        hazard_pkg::stage_tag_t wb
    );
        // Register 0 is hardwired and never forwarded
        if (a == '0)
            return hazard_pkg::FWD_RF;
        if (ex.dst == a)
            return (ex.tnew == 2'd0) ? hazard_pkg::FWD_EX : hazard_pkg::FWD_RF;
        if (mem.dst == a)
            return (mem.tnew == 2'd0) ? hazard_pkg::FWD_MEM : hazard_pkg::FWD_RF;
        if (wb.dst == a)
            return (wb.tnew == 2'd0) ? hazard_pkg::FWD_WB : hazard_pkg::FWD_RF;
        return hazard_pkg::FWD_RF;
    endfunction

    function automatic hazard_pkg::stage_tag_t tag_of(hazard_pkg::fwd_sel_t sel);
        case (sel)
            hazard_pkg::FWD_EX:  return ex_tag;
            hazard_pkg::FWD_MEM: return mem_tag;
            default:             return wb_tag;
        endcase
    endfunction

    assign fwd_rs = pick(rs, ex_tag, mem_tag, wb_tag);
    assign fwd_rt = pick(rt, ex_tag, mem_tag, wb_tag);

    // A bypass must name a stage that holds a finished result for that register
    always_comb begin
        if (fwd_rs != hazard_pkg::FWD_RF)
            a_fwd_rs_ready: assert (tag_of(fwd_rs).tnew == 2'd0 && tag_of(fwd_rs).dst == rs)
                else $error("rs forwarded from a stage without a ready result");
        if (fwd_rt != hazard_pkg::FWD_RF)
            a_fwd_rt_ready: assert (tag_of(fwd_rt).tnew == 2'd0 && tag_of(fwd_rt).dst == rt)
                else $error("rt forwarded from a stage without a ready result");
    end

endmodule

// ==== hazard_ctrl.sv ====
////////////////////////////////////////
// Hazard control
// Stall decision, ack side of the fetch
// handshake and the issue record register
////////////////////////////////////////

module hazard_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    output logic                   ack,
    input  hazard_pkg::instr_t     instr,
    input  hazard_pkg::decode_t    dec,
    input  hazard_pkg::stage_tag_t ex_tag,
    input  hazard_pkg::stage_tag_t mem_tag,
    input  hazard_pkg::stage_tag_t wb_tag,
    input  hazard_pkg::fwd_sel_t   fwd_rs,
    input  hazard_pkg::fwd_sel_t   fwd_rt,
    output logic                   issue,
    output logic                   issue_valid,
    output hazard_pkg::issue_t     issue_rec
);

    logic stall;

    // Result from this stage arrives after the source is needed
    function automatic logic late(
        hazard_pkg::reg_addr_t  a,
        hazard_pkg::t_t         tuse,
        hazard_pkg::stage_tag_t tag
    );
        return (a != '0) && (tag.dst == a) && (tag.tnew > tuse);
    endfunction

    assign stall = late(dec.rs, dec.tuse_rs, ex_tag)  ||
                   late(dec.rs, dec.tuse_rs, mem_tag) ||
                   late(dec.rs, dec.tuse_rs, wb_tag)  ||
                   late(dec.rt, dec.tuse_rt, ex_tag)  ||
                   late(dec.rt, dec.tuse_rt, mem_tag) ||
                   late(dec.rt, dec.tuse_rt, wb_tag);

    // Only a fresh request with ack low can issue
    assign issue = req && !ack && !stall;

    // ack is the handshake state, high from issue until req is seen low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue;
            if (issue)
                ack <= 1'b1;
            else if (ack && !req)
                ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue)
            issue_rec <= '{instr: instr, fwd_rs: fwd_rs, fwd_rt: fwd_rt};
    end

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req)
    ) else $error("ack rose without req");

    // Record goes out only for a cycle that was free of hazards
    a_issue_no_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid |-> (!$past(stall) && ack)
    ) else $error("issue during a stall");

endmodule

// ==== hazard_pkg.sv ====
////////////////////////////////////////
// Operand hazard package
// Instruction fields, timing counts, stage
// tags, forwarding selects and issue record
////////////////////////////////////////

package hazard_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // Tuse / Tnew count in cycles
    typedef logic [1:0]  t_t;

    // Operand not read by the instruction
    localparam t_t TUSE_INF = 2'd3;

    // Return address register written by jal
    localparam reg_addr_t REG_RA = 5'd31;

    // Opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // SPECIAL funct codes
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;

    // Field view of an instruction word
    typedef struct packed {
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_t    funct;
    } fields_t;

    // Write tag of one pipeline stage, dst 0 is a bubble
    typedef struct packed {
        reg_addr_t dst;
        t_t        tnew;
    } stage_tag_t;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dst;
        t_t        tuse_rs;
        t_t        tuse_rt;
        t_t        tnew;
    } decode_t;

    typedef struct packed {
        instr_t   instr;
        fwd_sel_t fwd_rs;
        fwd_sel_t fwd_rt;
    } issue_t;

endpackage

// ==== hazard_model.svh ====
////////////////////////////////////////
// Reference model of the hazard unit
// Decode tables, stage tags, stall and
// forwarding rules of the ID stage
////////////////////////////////////////

`ifndef HAZARD_MODEL_SVH
`define HAZARD_MODEL_SVH

hazard_pkg::stage_tag_t m_ex;
hazard_pkg::stage_tag_t m_mem;
hazard_pkg::stage_tag_t m_wb;

function automatic hazard_pkg::decode_t model_decode(hazard_pkg::instr_t w);
    hazard_pkg::decode_t d;
    logic [5:0] op;
    logic [5:0] fn;
    op = w[31:26];
    fn = w[5:0];
    d = '{rs: w[25:21], rt: w[20:16], dst: 5'd0, tuse_rs: 2'd3, tuse_rt: 2'd3, tnew: 2'd0};
    if (op == 6'h00 && (fn == 6'h21 || fn == 6'h23)) begin
        d.dst = w[15:11];
        d.tuse_rs = 2'd1;
        d.tuse_rt = 2'd1;
        d.tnew = 2'd2;
    end else if (op == 6'h00 && fn == 6'h00) begin
        d.dst = w[15:11];
        d.tuse_rt = 2'd1;
        d.tnew = 2'd2;
    end else if (op == 6'h0d) begin
        d.dst = w[20:16];
        d.tuse_rs = 2'd1;
        d.tnew = 2'd2;
    end else if (op == 6'h0f) begin
        d.dst = w[20:16];
        d.tnew = 2'd1;
    end else if (op == 6'h23) begin
        d.dst = w[20:16];
        d.tuse_rs = 2'd1;
        d.tnew = 2'd3;
    end else if (op == 6'h2b) begin
        d.tuse_rs = 2'd1;
        d.tuse_rt = 2'd2;
    end else if (op == 6'h04) begin
        d.tuse_rs = 2'd0;
        d.tuse_rt = 2'd0;
    end else if (op == 6'h03) begin
        d.dst = 5'd31;
        d.tnew = 2'd1;
    end
    return d;
endfunction

function automatic hazard_pkg::stage_tag_t aged(hazard_pkg::stage_tag_t t);
    hazard_pkg::stage_tag_t r;
    r.dst = t.dst;
    r.tnew = (t.tnew != 2'd0) ? t.tnew - 2'd1 : 2'd0;
    return r;
endfunction

// One clock edge, bubble when nt is all zero
task automatic model_shift(input hazard_pkg::stage_tag_t nt);
    m_wb = aged(m_mem);
    m_mem = aged(m_ex);
    m_ex = aged(nt);
endtask

function automatic bit model_late(hazard_pkg::reg_addr_t a, hazard_pkg::t_t tuse);
    if (a == 5'd0)
        return 1'b0;
    return (m_ex.dst == a && m_ex.tnew > tuse) || (m_mem.dst == a && m_mem.tnew > tuse) ||
           (m_wb.dst == a && m_wb.tnew > tuse);
endfunction

function automatic hazard_pkg::fwd_sel_t model_fwd(hazard_pkg::reg_addr_t a);
    if (a == 5'd0)
        return hazard_pkg::FWD_RF;
    if (m_ex.dst == a)
        return (m_ex.tnew == 2'd0) ? hazard_pkg::FWD_EX : hazard_pkg::FWD_RF;
    if (m_mem.dst == a)
        return (m_mem.tnew == 2'd0) ? hazard_pkg::FWD_MEM : hazard_pkg::FWD_RF;
    if (m_wb.dst == a)
        return (m_wb.tnew == 2'd0) ? hazard_pkg::FWD_WB : hazard_pkg::FWD_RF;
    return hazard_pkg::FWD_RF;
endfunction

// Bubbles until no source is late, then the issue edge itself
task automatic model_issue(input hazard_pkg::instr_t w, output hazard_pkg::issue_t rec,
                           output int stalls);
    hazard_pkg::decode_t d;
    d = model_decode(w);
    stalls = 0;
    while ((model_late(d.rs, d.tuse_rs) || model_late(d.rt, d.tuse_rt)) && stalls < 8) begin
        model_shift('0);
        stalls++;
    end
    rec.instr = w;
    rec.fwd_rs = model_fwd(d.rs);
    rec.fwd_rt = model_fwd(d.rt);
    model_shift('{dst: d.dst, tnew: d.tnew});
endtask

`endif

// ==== hazard_tb.sv ====
////////////////////////////////////////
// Testbench for the operand hazard unit
// Directed and random programs over the
// fetch handshake, checked against a model
////////////////////////////////////////

module hazard_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst_n;
    logic req;
    logic ack;
    hazard_pkg::instr_t instr;
    logic issue_valid;
    hazard_pkg::issue_t issue_rec;

    integer seed = 32'h17fc;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int total_exp = 0;
    int total_seen = 0;
    bit timed_out = 1'b0;

    `include "hazard_model.svh"

    hazard_top hazard_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .ack         (ack),
        .instr       (instr),
        .issue_valid (issue_valid),
        .issue_rec   (issue_rec)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic note_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic check_issue(input string name, input hazard_pkg::issue_t got,
                               input hazard_pkg::issue_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_fwd(input string name, input hazard_pkg::fwd_sel_t got,
                             input hazard_pkg::fwd_sel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic hazard_pkg::instr_t enc_r(int rs, int rt, int rd, logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic hazard_pkg::instr_t enc_i(logic [5:0] op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic hazard_pkg::instr_t random_instr();
        int k;
        int a;
        int b;
        int c;
        k = $unsigned($random(seed)) % 10;
        a = $unsigned($random(seed)) % 4;
        b = $unsigned($random(seed)) % 4;
        c = $unsigned($random(seed)) % 4;
        case (k)
            0: return enc_r(a, b, c, 6'h21);
            1: return enc_r(a, b, c, 6'h23);
            2: return enc_r(a, b, c, 6'h00);
            3: return enc_i(6'h0d, a, b, $random(seed));
            4: return enc_i(6'h0f, a, b, $random(seed));
            5: return enc_i(6'h23, a, b, 4 * c);
            6: return enc_i(6'h2b, a, b, 4 * c);
            7: return enc_i(6'h04, a, b, c);
            8: return {6'h03, 26'h40};
            default: return 32'h0;
        endcase
    endfunction

    // One full four-phase handshake, hold keeps req high after ack
    task automatic run_instr(input hazard_pkg::instr_t w, input int hold,
                             output hazard_pkg::issue_t rec, output int stalls);
        hazard_pkg::issue_t exp;
        int exp_st;
        int n;
        rec = '0;
        stalls = 0;
        if (timed_out)
            return;
        model_issue(w, exp, exp_st);
        req = 1'b1;
        instr = w;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack && n < 8);
        if (!ack) begin
            note_error("ack did not rise within 8 cycles of req");
            timed_out = 1'b1;
            return;
        end
        if (!issue_valid)
            note_error("ack rose without an issue_valid pulse");
        check_issue("issue_rec", issue_rec, exp);
        stalls = n - 1;
        check_count("stall_cycles", stalls, exp_st);
        total_exp += exp_st;
        total_seen += stalls;
        rec = issue_rec;
        repeat (hold) begin
            @(negedge clk);
            model_shift('0);
            if (!ack)
                note_error("ack fell while req was still high");
            if (issue_valid)
                note_error("second record within one handshake");
        end
        req = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            model_shift('0);
            if (issue_valid)
                note_error("second record within one handshake");
        end while (ack && n < 4);
        if (ack) begin
            note_error("ack did not fall within 4 cycles of req falling");
            timed_out = 1'b1;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("%s: %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        hazard_pkg::issue_t rec;
        int st;
        int e0;
        int exp0;
        int seen0;
        rst_n = 1'b0;
        req = 1'b0;
        instr = '0;
        m_ex = '0;
        m_mem = '0;
        m_wb = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        repeat (3) begin
            @(negedge clk);
            model_shift('0);
            if (ack || issue_valid)
                note_error("ack or issue_valid high with no request");
        end
        run_instr(enc_i(6'h0d, 0, 1, 16'h1234), 0, rec, st);
        check_count("stall_cycles", st, 0);
        end_test("reset and first issue", e0);

        e0 = errors;
        run_instr(enc_i(6'h23, 1, 2, 4), 0, rec, st);
        run_instr(enc_r(2, 1, 3, 6'h21), 0, rec, st);
        end_test("load-use", e0);

        e0 = errors;
        run_instr(enc_r(2, 3, 1, 6'h21), 0, rec, st);
        run_instr(enc_i(6'h04, 1, 2, 8), 0, rec, st);
        // Load result still pending when the store data is read
        run_instr(enc_i(6'h23, 1, 2, 0), 0, rec, st);
        run_instr(enc_i(6'h2b, 3, 2, 0), 0, rec, st);
        check_count("stall_cycles", st, 0);
        end_test("branch and store timing", e0);

        e0 = errors;
        run_instr(enc_i(6'h23, 1, 0, 0), 0, rec, st);
        run_instr(enc_i(6'h04, 0, 0, 4), 0, rec, st);
        check_count("stall_cycles", st, 0);
        check_fwd("fwd_rs", rec.fwd_rs, hazard_pkg::FWD_RF);
        check_fwd("fwd_rt", rec.fwd_rt, hazard_pkg::FWD_RF);
        run_instr(enc_i(6'h23, 2, 1, 0), 0, rec, st);
        // sll reads only rt, rs holds the loaded register
        run_instr(enc_r(1, 3, 2, 6'h00), 0, rec, st);
        check_count("stall_cycles", st, 0);
        run_instr(enc_i(6'h23, 2, 1, 0), 0, rec, st);
        run_instr(enc_i(6'h0f, 1, 1, 16'h00ff), 0, rec, st);
        check_count("stall_cycles", st, 0);
        end_test("register zero and unused sources", e0);

        e0 = errors;
        run_instr(enc_i(6'h23, 1, 2, 0), 2, rec, st);
        run_instr(enc_r(2, 2, 3, 6'h21), 3, rec, st);
        run_instr(enc_i(6'h04, 3, 2, 4), 1, rec, st);
        end_test("four-phase order", e0);

        e0 = errors;
        exp0 = total_exp;
        seen0 = total_seen;
        for (int i = 0; i < 300 && !timed_out; i++) begin
            run_instr(random_instr(), $unsigned($random(seed)) % 2, rec, st);
            repeat ($unsigned($random(seed)) % 2) begin
                @(negedge clk);
                model_shift('0);
            end
        end
        check_count("total_stalls", total_seen - seen0, total_exp - exp0);
        end_test("random program", e0);

        $display("tests %0d, checks %0d, errors %0d, stall cycles %0d",
                 tests, checks, errors, total_seen);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== hazard_top.sv ====
////////////////////////////////////////
// Operand hazard unit top
// Decode, stage tags, forwarding and
// issue control for the ID stage
////////////////////////////////////////

module hazard_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    output logic               ack,
    input  hazard_pkg::instr_t instr,
    output logic               issue_valid,
    output hazard_pkg::issue_t issue_rec
);

    hazard_pkg::decode_t    dec;
    hazard_pkg::stage_tag_t new_tag;
    hazard_pkg::stage_tag_t ex_tag;
    hazard_pkg::stage_tag_t mem_tag;
    hazard_pkg::stage_tag_t wb_tag;
    hazard_pkg::fwd_sel_t   fwd_rs;
    hazard_pkg::fwd_sel_t   fwd_rt;
    logic                   issue;

    // Tag entering EX for the instruction held in ID
    assign new_tag = '{dst: dec.dst, tnew: dec.tnew};

    instr_decode instr_decode_i (
        .instr (instr),
        .dec   (dec)
    );

    stage_tracker stage_tracker_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (issue),
        .new_tag (new_tag),
        .ex_tag  (ex_tag),
        .mem_tag (mem_tag),
        .wb_tag  (wb_tag)
    );

    forward_sel forward_sel_i (
        .rs      (dec.rs),
        .rt      (dec.rt),
        .ex_tag  (ex_tag),
        .mem_tag (mem_tag),
        .wb_tag  (wb_tag),
        .fwd_rs  (fwd_rs),
        .fwd_rt  (fwd_rt)
    );

    hazard_ctrl hazard_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .ack         (ack),
        .instr       (instr),
        .dec         (dec),
        .ex_tag      (ex_tag),
        .mem_tag     (mem_tag),
        .wb_tag      (wb_tag),
        .fwd_rs      (fwd_rs),
        .fwd_rt      (fwd_rt),
        .issue       (issue),
        .issue_valid (issue_valid),
        .issue_rec   (issue_rec)
    );

endmodule

// ==== instr_decode.sv ====
////////////////////////////////////////
// Instruction decode for hazard checks
// Gives source registers, Tuse per source,
// Tnew at ID and the written register
////////////////////////////////////////

module instr_decode (
    input  hazard_pkg::instr_t  instr,
    output hazard_pkg::decode_t dec
);

    hazard_pkg::fields_t f;

    assign f = instr;

    always_comb begin
        // Defaults describe a nop
        dec.rs      = f.rs;
        dec.rt      = f.rt;
        dec.dst     = '0;
        dec.tuse_rs = hazard_pkg::TUSE_INF;
        dec.tuse_rt = hazard_pkg::TUSE_INF;
        dec.tnew    = 2'd0;

        case (f.op)
            hazard_pkg::OP_SPECIAL: begin
                case (f.funct)
                    hazard_pkg::FN_ADDU,
                    hazard_pkg::FN_SUBU: begin
                        dec.dst     = f.rd;
                        dec.tuse_rs = 2'd1;
                        dec.tuse_rt = 2'd1;
                        dec.tnew    = 2'd2;
                    end
                    hazard_pkg::FN_SLL: begin
                        // Shift amount comes from the word, rs unused
                        dec.dst     = f.rd;
                        dec.tuse_rt = 2'd1;
                        dec.tnew    = 2'd2;
                    end
                    default: ;
                endcase
            end
            hazard_pkg::OP_ORI: begin
                dec.dst     = f.rt;
                dec.tuse_rs = 2'd1;
                dec.tnew    = 2'd2;
            end
            hazard_pkg::OP_LUI: begin
                dec.dst  = f.rt;
                dec.tnew = 2'd1;
            end
            hazard_pkg::OP_LW: begin
                dec.dst     = f.rt;
                dec.tuse_rs = 2'd1;
                dec.tnew    = 2'd3;
            end
            hazard_pkg::OP_SW: begin
                // Store data is only needed in MEM
                dec.tuse_rs = 2'd1;
                dec.tuse_rt = 2'd2;
            end
            hazard_pkg::OP_BEQ: begin
                // Compare happens in ID
                dec.tuse_rs = 2'd0;
                dec.tuse_rt = 2'd0;
            end
            hazard_pkg::OP_JAL: begin
                dec.dst  = hazard_pkg::REG_RA;
                dec.tnew = 2'd1;
            end
            default: ;
        endcase
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the hazard unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module hazard_tb -o hazard_sim
./obj_dir/hazard_sim > sim.log
cat sim.log

if grep -qx -- '>>> PASS' sim.log; then
    exit 0
fi
exit 1

// ==== stage_tracker.sv ====
////////////////////////////////////////
// Pipeline write-tag tracker
// Shifts EX, MEM and WB tags each cycle and
// counts Tnew down toward zero
////////////////////////////////////////

module stage_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue,
    input  hazard_pkg::stage_tag_t new_tag,
    output hazard_pkg::stage_tag_t ex_tag,
    output hazard_pkg::stage_tag_t mem_tag,
    output hazard_pkg::stage_tag_t wb_tag
);

    // One stage later, with Tnew saturating at zero
    function automatic hazard_pkg::stage_tag_t advance(hazard_pkg::stage_tag_t tag);
        hazard_pkg::stage_tag_t nxt;
        nxt.dst  = tag.dst;
        nxt.tnew = (tag.tnew == 2'd0) ? 2'd0 : tag.tnew - 2'd1;
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_tag  <= '0;
            mem_tag <= '0;
            wb_tag  <= '0;
        end else begin
            // No issue means a bubble enters EX
            ex_tag  <= issue ? advance(new_tag) : '0;
            mem_tag <= advance(ex_tag);
            wb_tag  <= advance(mem_tag);
        end
    end

    // Decode Tnew tops out at 3 (lw), one cycle is spent in ID
    a_ex_tnew_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        ex_tag.tnew <= 2'd2
    ) else $error("EX tag tnew above 2");

endmodule

// ==== tb.f ====
+incdir+.
hazard_pkg.sv
instr_decode.sv
stage_tracker.sv
forward_sel.sv
hazard_ctrl.sv
hazard_top.sv
hazard_tb.sv
